// File: source/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath widths.
`define EXEC_XLEN 64
`define EXEC_HALF 32

// shift amount bits taken from operand b.
`define EXEC_SHAMT_W 6
`define EXEC_SHAMTW_W 5

`define EXEC_CTRL_W 5

`endif

// File: source/exec_pkg.sv
`default_nettype none
`include "exec_cfg.svh"

package exec_pkg;

    // bit 4 word op, bit 3 arithmetic, bits 2..0 select.
    typedef logic [`EXEC_CTRL_W-1:0] alu_ctrl_t;

    typedef enum logic [2:0] {
        SEL_ADD  = 3'd0,
        SEL_SLL  = 3'd1,
        SEL_SLTU = 3'd2,  // borrow of a - b.
        SEL_SLT  = 3'd3,
        SEL_XOR  = 3'd4,
        SEL_SR   = 3'd5,  // srl, or sra with bit 3.
        SEL_OR   = 3'd6,
        SEL_AND  = 3'd7   // pass b with bit 3.
    } alu_sel_e;

    typedef enum logic [1:0] {
        CLASS_OP     = 2'd0,
        CLASS_OPIMM  = 2'd1,
        CLASS_BRANCH = 2'd2,
        CLASS_LUI    = 2'd3
    } exec_class_e;

endpackage

`default_nettype wire

// File: source/exec_adder.sv
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module exec_adder (
    input  wire [`EXEC_XLEN-1:0] x,
    input  wire [`EXEC_XLEN-1:0] y,
    input  wire                  sub,
    output logic [`EXEC_XLEN-1:0] sum,
    output logic                 carry_flag,
    output logic                 zero_flag,
    output logic                 sign_flag,
    output logic                 overflow_flag
);

    logic [`EXEC_XLEN-1:0] y_inv;
    logic [`EXEC_XLEN-2:0] sum_low;
    logic                  sum_top;
    logic                  carry_top_in;
    logic                  carry_out;

    assign y_inv = sub ? ~y : y;

    // split at the sign bit so its carry in is visible for overflow.
    assign {carry_top_in, sum_low} = {1'b0, x[`EXEC_XLEN-2:0]} + {1'b0, y_inv[`EXEC_XLEN-2:0]}
                                   + {{(`EXEC_XLEN-1){1'b0}}, sub};
    assign {carry_out, sum_top} = {1'b0, x[`EXEC_XLEN-1]} + {1'b0, y_inv[`EXEC_XLEN-1]}
                                + {1'b0, carry_top_in};

    assign sum           = {sum_top, sum_low};
    assign carry_flag    = sub ^ carry_out;  // borrow when subtracting.
    assign zero_flag     = ~(|sum);
    assign sign_flag     = sum_top;
    assign overflow_flag = carry_out ^ carry_top_in;

endmodule

`default_nettype wire

// File: source/exec_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module exec_alu (
    input  wire [`EXEC_XLEN-1:0] a,
    input  wire [`EXEC_XLEN-1:0] b,
    input  wire exec_pkg::alu_ctrl_t ctrl,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                 zero,
    output logic                 lt_flag
);

    logic                     sub_mode;
    logic                     arith_mode;
    logic                     word_mode;
    logic [`EXEC_XLEN-1:0]    sum;
    logic                     carry;
    logic                     sign;
    logic                     overflow;
    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic [`EXEC_SHAMTW_W-1:0] shamt_w;
    logic [`EXEC_XLEN-1:0]    srl_d;
    logic [`EXEC_XLEN-1:0]    sra_d;
    logic [`EXEC_HALF-1:0]    sll_w;
    logic [`EXEC_HALF-1:0]    srl_w;
    logic [`EXEC_HALF-1:0]    sra_w;

    assign sub_mode   = ctrl[3] | ctrl[1];  // compares subtract too.
    assign arith_mode = ctrl[3];
    assign word_mode  = ctrl[4];

    exec_adder adder0 (
        .x            (a),
        .y            (b),
        .sub          (sub_mode),
        .sum          (sum),
        .carry_flag   (carry),
        .zero_flag    (zero),
        .sign_flag    (sign),
        .overflow_flag(overflow)
    );

    assign shamt   = b[`EXEC_SHAMT_W-1:0];
    assign shamt_w = b[`EXEC_SHAMTW_W-1:0];

    assign srl_d = a >> shamt;
    assign sra_d = $signed(a) >>> shamt;
    assign sll_w = a[`EXEC_HALF-1:0] << shamt_w;
    assign srl_w = a[`EXEC_HALF-1:0] >> shamt_w;
    assign sra_w = $signed(a[`EXEC_HALF-1:0]) >>> shamt_w;

    always_comb begin
        case (exec_pkg::alu_sel_e'(ctrl[2:0]))
            exec_pkg::SEL_ADD:
                result = word_mode ? {{`EXEC_HALF{sum[`EXEC_HALF-1]}}, sum[`EXEC_HALF-1:0]} : sum;
            exec_pkg::SEL_SLL:
                result = word_mode ? {{`EXEC_HALF{sll_w[`EXEC_HALF-1]}}, sll_w} : a << shamt;
            exec_pkg::SEL_SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, carry};
            exec_pkg::SEL_SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, overflow ^ sign};
            exec_pkg::SEL_XOR:  result = a ^ b;
            exec_pkg::SEL_SR: begin
                if (word_mode && arith_mode) result = {{`EXEC_HALF{sra_w[`EXEC_HALF-1]}}, sra_w};
                else if (word_mode)          result = {{`EXEC_HALF{srl_w[`EXEC_HALF-1]}}, srl_w};
                else if (arith_mode)         result = sra_d;
                else                         result = srl_d;
            end
            exec_pkg::SEL_OR:   result = a | b;
            exec_pkg::SEL_AND:  result = ({`EXEC_XLEN{arith_mode}} | a) & b;
        endcase
    end

    assign lt_flag = result[0];

endmodule

`default_nettype wire

// File: source/exec_op_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module exec_op_decode (
    input  wire exec_pkg::exec_class_e op_class,
    input  wire [2:0]                  funct3,
    input  wire                        funct7_5,
    input  wire                        is_word,
    output exec_pkg::alu_ctrl_t        ctrl
);

    logic [2:0] sel;
    logic       arith;
    logic       word;
    logic       sub_ok;

    // only register ops may subtract, immediates never do.
    assign sub_ok = (op_class == exec_pkg::CLASS_OP) && (funct3 == 3'd0);

    always_comb begin
        sel   = exec_pkg::SEL_ADD;
        arith = 1'b0;
        word  = 1'b0;
        case (op_class)
            exec_pkg::CLASS_OP, exec_pkg::CLASS_OPIMM: begin
                // slt and sltu sit swapped in the select space.
                case (funct3)
                    3'd2:    sel = exec_pkg::SEL_SLT;
                    3'd3:    sel = exec_pkg::SEL_SLTU;
                    default: sel = funct3;
                endcase
                arith = funct7_5 & ((funct3 == 3'd5) | sub_ok);
                word  = is_word;
            end
            exec_pkg::CLASS_BRANCH: begin
                case (funct3[2:1])
                    2'b10: sel = exec_pkg::SEL_SLT;   // blt, bge.
                    2'b11: sel = exec_pkg::SEL_SLTU;  // bltu, bgeu.
                    default: begin
                        sel   = exec_pkg::SEL_ADD;    // beq, bne compare a - b.
                        arith = 1'b1;
                    end
                endcase
            end
            exec_pkg::CLASS_LUI: begin
                sel   = exec_pkg::SEL_AND;
                arith = 1'b1;  // and with all ones passes b.
            end
        endcase
    end

    assign ctrl = {word, arith, sel};

endmodule

`default_nettype wire

// File: source/exec_branch.sv
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module exec_branch (
    input  wire       is_branch,
    input  wire [2:0] funct3,
    input  wire       zero,
    input  wire       lt_flag,
    output logic      taken
);

    logic cond;
    logic valid_code;

    // funct3 bit 2 picks compare over equality.
    assign cond = funct3[2] ? lt_flag : zero;

    // codes 2 and 3 are not branches.
    assign valid_code = (funct3[2:1] != 2'b01);

    // bit 0 inverts the test: bne, bge, bgeu.
    assign taken = is_branch & valid_code & (cond ^ funct3[0]);

endmodule

`default_nettype wire

// File: source/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "exec_cfg.svh"

module exec_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        in_valid,
    input  wire exec_pkg::exec_class_e op_class,
    input  wire [2:0]                  funct3,
    input  wire                        funct7_5,
    input  wire                        is_word,
    input  wire [`EXEC_XLEN-1:0]       a,
    input  wire [`EXEC_XLEN-1:0]       b,
    output logic                       out_valid,
    output logic [`EXEC_XLEN-1:0]      out_result,
    output logic                       out_taken
);

    exec_pkg::alu_ctrl_t   ctrl;
    logic [`EXEC_XLEN-1:0] result;
    logic                  zero;
    logic                  lt_flag;
    logic                  is_branch;
    logic                  taken;

    assign is_branch = (op_class == exec_pkg::CLASS_BRANCH);

    exec_op_decode decode0 (
        .op_class(op_class),
        .funct3  (funct3),
        .funct7_5(funct7_5),
        .is_word (is_word),
        .ctrl    (ctrl)
    );

    exec_alu alu0 (
        .a      (a),
        .b      (b),
        .ctrl   (ctrl),
        .result (result),
        .zero   (zero),
        .lt_flag(lt_flag)
    );

    exec_branch branch0 (
        .is_branch(is_branch),
        .funct3   (funct3),
        .zero     (zero),
        .lt_flag  (lt_flag),
        .taken    (taken)
    );

    // one stage, a new op may enter every cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_result <= '0;
            out_taken  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_result <= result;
                out_taken  <= taken;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        out_valid,
    input  wire [63:0] out_result,
    input  wire        out_taken,
    input  wire        exp_valid,
    input  wire [7:0]  exp_idx,
    input  wire [63:0] exp_result,
    input  wire        exp_taken,
    output int         checks,
    output int         errors
);

    string names [0:27];
    logic  seen_edge;

    initial begin
        names = '{"add_wrap", "sub_neg", "addw_ext", "subw_ext", "slli_63", "sll_mask",
                  "sllw_31", "srl_32", "sra_63", "sraiw_31", "slt_neg", "sltu_big",
                  "slt_ovf", "xor", "or", "and", "lui", "beq_eq", "bne_gt", "blt_lt",
                  "bge_eq", "bltu_lt", "bgeu_gt", "srlw_33", "rand_add", "rand_xor",
                  "rand_or", "rand_lui"};
        checks    = 0;
        errors    = 0;
        seen_edge = 1'b0;
    end

    // top index bit marks a branch run with the inverse condition.
    function automatic string test_name(input logic [7:0] idx);
        if (idx[7]) begin
            return {names[idx[6:0]], "_inv"};
        end
        return names[idx];
    endfunction

    always @(posedge clk) seen_edge <= 1'b1;

    // outputs are settled half a cycle after the edge.
    always @(negedge clk) begin
        if (!rst_n && seen_edge &&
            (out_valid !== 1'b0 || out_taken !== 1'b0 || out_result !== 64'd0)) begin
            errors = errors + 1;
            $display("outputs are not cleared during reset");
        end else if (rst_n && exp_valid) begin
            checks = checks + 1;
            if (out_valid !== 1'b1) begin
                errors = errors + 1;
                $display("%s: out_valid did not rise one cycle after in_valid",
                         test_name(exp_idx));
            end else if (out_result !== exp_result || out_taken !== exp_taken) begin
                errors = errors + 1;
                $display("** Error %s: expected result %h taken %b, actual result %h taken %b",
                         test_name(exp_idx), exp_result, exp_taken, out_result, out_taken);
            end else begin
                $display("pass %s: result %h taken %b", test_name(exp_idx), out_result,
                         out_taken);
            end
        end else if (rst_n && out_valid !== 1'b0) begin
            errors = errors + 1;
            $display("out_valid rose without an operation one cycle before");
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    exec_pkg::exec_class_e op_class;
    logic [2:0]            funct3;
    logic                  funct7_5;
    logic                  is_word;
    logic [63:0]           a;
    logic [63:0]           b;
    logic                  out_valid;
    logic [63:0]           out_result;
    logic                  out_taken;
    logic [7:0]            cur_idx;
    logic [63:0]           cur_result;
    logic                  cur_taken;
    logic                  exp_valid;
    logic [7:0]            exp_idx;
    logic [63:0]           exp_result;
    logic                  exp_taken;
    logic [219:0]          tests [0:63];
    int                    num_tests;
    int                    num_pairs;
    int                    num_ops;
    int                    cycles;
    int                    limit;
    int                    checks;
    int                    errors;
    integer                seed;

    tb_clock clock0 (.clk(clk), .rst_n(rst_n));

    exec_stage dut0 (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .op_class(op_class),
        .funct3(funct3), .funct7_5(funct7_5), .is_word(is_word), .a(a), .b(b),
        .out_valid(out_valid), .out_result(out_result), .out_taken(out_taken)
    );

    tb_checker checker0 (
        .clk(clk), .rst_n(rst_n), .out_valid(out_valid), .out_result(out_result),
        .out_taken(out_taken), .exp_valid(exp_valid), .exp_idx(exp_idx),
        .exp_result(exp_result), .exp_taken(exp_taken), .checks(checks), .errors(errors)
    );

    // expectations follow the inputs by one cycle, like the DUT.
    always @(posedge clk) begin
        exp_valid  <= in_valid;
        exp_idx    <= cur_idx;
        exp_result <= cur_result;
        exp_taken  <= cur_taken;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, outputs stopped arriving", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // branch records with a valid code also run with the inverse condition.
    function automatic logic has_inverse(input logic [219:0] rec);
        return rec[209:208] == 2'd2 && rec[206:205] != 2'b01;
    endfunction

    task automatic drive_op(input logic [7:0] idx, input logic [1:0] cls, input logic [2:0] f3,
                            input logic f75, input logic word, input logic [63:0] op_a,
                            input logic [63:0] op_b, input logic [63:0] exp, input logic tk);
        @(posedge clk);
        in_valid   <= 1'b1;
        op_class   <= exec_pkg::exec_class_e'(cls);
        funct3     <= f3;
        funct7_5   <= f75;
        is_word    <= word;
        a          <= op_a;
        b          <= op_b;
        cur_idx    <= idx;
        cur_result <= exp;
        cur_taken  <= tk;
    endtask

    initial begin
        logic [63:0] ra;
        logic [63:0] rb;
        logic [31:0] pick;
        in_valid = 1'b0;
        op_class = exec_pkg::CLASS_OP;
        funct3 = 3'd0;
        funct7_5 = 1'b0;
        is_word = 1'b0;
        a = '0;
        b = '0;
        cur_idx = '0;
        cur_result = '0;
        cur_taken = 1'b0;
        exp_valid = 1'b0;
        cycles = 0;
        limit = 0;
        seed = 32'ha5e46d35;
        for (int i = 0; i < 64; i++) tests[i] = '1;
        $readmemh("testbench/exec_tests.txt", tests);
        num_tests = 0;
        num_pairs = 0;
        while (num_tests < 64 && tests[num_tests][219:212] != 8'hff) begin
            if (has_inverse(tests[num_tests])) num_pairs++;
            num_tests++;
        end
        num_ops = num_tests + num_pairs + 1 + 16;  // file, inverse branches, srlw, random.
        limit = 8 + num_ops + 20;
        wait (rst_n === 1'b1);
        for (int i = 0; i < num_tests; i++) begin
            drive_op(tests[i][219:212], tests[i][209:208], tests[i][206:204], tests[i][200],
                     tests[i][196], tests[i][195:132], tests[i][131:68], tests[i][67:4],
                     tests[i][0]);
            if (has_inverse(tests[i])) begin
                // same compare, so only taken flips.
                drive_op(tests[i][219:212] | 8'h80, tests[i][209:208],
                         tests[i][206:204] ^ 3'd1, tests[i][200], tests[i][196],
                         tests[i][195:132], tests[i][131:68], tests[i][67:4],
                         ~tests[i][0]);
            end
        end
        // srlw uses five amount bits and sign-extends bit 31 of the word.
        drive_op(8'd23, 2'd0, 3'd5, 1'b0, 1'b1, 64'hffffffff80000000, 64'h21,
                 64'h0000000040000000, 1'b0);
        // random add, xor, or and lui.
        for (int i = 0; i < 16; i++) begin
            ra   = {$random(seed), $random(seed)};
            rb   = {$random(seed), $random(seed)};
            pick = $random(seed);
            case (pick[1:0])
                2'd0: drive_op(8'd24, 2'd0, 3'd0, 1'b0, 1'b0, ra, rb, ra + rb, 1'b0);
                2'd1: drive_op(8'd25, 2'd0, 3'd4, 1'b0, 1'b0, ra, rb, ra ^ rb, 1'b0);
                2'd2: drive_op(8'd26, 2'd0, 3'd6, 1'b0, 1'b0, ra, rb, ra | rb, 1'b0);
                default: drive_op(8'd27, 2'd3, 3'd0, 1'b0, 1'b0, ra, rb, rb, 1'b0);
            endcase
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait (checks == num_ops);
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/exec_pkg.sv
source/exec_adder.sv
source/exec_alu.sv
source/exec_op_decode.sv
source/exec_branch.sv
source/exec_stage.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: testbench/exec_tests.txt
// idx_class_funct3_funct7b5_word_a_b_expected-result_expected-taken, all hex
// class 0 op, 1 op-imm, 2 branch, 3 lui
00_0_0_0_0_7FFFFFFFFFFFFFFF_0000000000000001_8000000000000000_0
01_0_0_1_0_0000000000000000_0000000000000001_FFFFFFFFFFFFFFFF_0
02_0_0_0_1_000000007FFFFFFF_0000000000000001_FFFFFFFF80000000_0
03_0_0_1_1_0000000100000000_0000000000000001_FFFFFFFFFFFFFFFF_0
04_1_1_0_0_0000000000000001_000000000000003F_8000000000000000_0
05_0_1_0_0_0123456789ABCDEF_0000000000000040_0123456789ABCDEF_0
06_0_1_0_1_0000000000000001_000000000000001F_FFFFFFFF80000000_0
07_0_5_0_0_8000000000000000_0000000000000020_0000000080000000_0
08_0_5_1_0_8000000000000000_000000000000003F_FFFFFFFFFFFFFFFF_0
09_1_5_1_1_0000000080000000_000000000000001F_FFFFFFFFFFFFFFFF_0
0A_0_2_0_0_FFFFFFFFFFFFFFFF_0000000000000001_0000000000000001_0
0B_0_3_0_0_FFFFFFFFFFFFFFFF_0000000000000001_0000000000000000_0
0C_0_2_0_0_8000000000000000_0000000000000001_0000000000000001_0
0D_0_4_0_0_FF00FF00FF00FF00_0F0F0F0F0F0F0F0F_F00FF00FF00FF00F_0
0E_0_6_0_0_FF00FF00FF00FF00_0F0F0F0F0F0F0F0F_FF0FFF0FFF0FFF0F_0
0F_0_7_0_0_FF00FF00FF00FF00_0F0F0F0F0F0F0F0F_0F000F000F000F00_0
10_3_0_0_0_123456789ABCDEF0_FFFFFFFFABCDE000_FFFFFFFFABCDE000_0
11_2_0_0_0_0000000000000005_0000000000000005_0000000000000000_1
12_2_1_0_0_0000000000000009_0000000000000003_0000000000000006_1
13_2_4_0_0_FFFFFFFFFFFFFFFE_0000000000000003_0000000000000001_1
14_2_5_0_0_0000000000000005_0000000000000005_0000000000000000_1
15_2_6_0_0_0000000000000003_0000000000000009_0000000000000001_1
16_2_7_0_0_FFFFFFFFFFFFFFFE_0000000000000003_0000000000000000_1
